// ==== npc_pkg.sv ====
`default_nettype none

package npc_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  localparam xlen_t RESET_PC   = 32'h8000_0000;
  localparam xlen_t DMEM_BASE  = 32'h8000_1000;
  localparam int    IMEM_WORDS = 256;
  localparam int    DMEM_WORDS = 256;
  localparam int    IMEM_AW    = $clog2(IMEM_WORDS);
  localparam int    DMEM_AW    = $clog2(DMEM_WORDS);

  typedef logic [IMEM_AW-1:0] imem_addr_t; // Word index into instruction memory.
  typedef logic [DMEM_AW-1:0] dmem_addr_t; // Word index into data memory.

  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  localparam inst_t INST_EBREAK = 32'h0010_0073;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {NPC_SNPC, NPC_DNPC, NPC_JALR, NPC_BRANCH} npc_sel_e;
  typedef enum logic [1:0] {WB_ALU, WB_SNPC, WB_DNPC, WB_MEM} wb_sel_e;
  typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

  typedef struct packed {
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    logic      reg_wen;
    wb_sel_e   wb_sel;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      use_pc;   // Operand a is the pc, as for auipc.
    logic      br_inv;   // Inverts the branch condition for bne, bge and bgeu.
    npc_sel_e  npc_sel;
    logic      mem_ren;
    logic      mem_wen;
    mem_size_e mem_size;
    logic      mem_sext;
    logic      halt;
  } ctrl_t;

  typedef struct packed {
    xlen_t    pc;
    inst_t    inst;
    logic     rd_wen;
    reg_idx_t rd;
    xlen_t    rd_data;
    xlen_t    next_pc;
  } commit_t;

  typedef struct packed {
    imem_addr_t addr;
    inst_t      data;
  } prog_t;

endpackage

`default_nettype wire

// ==== npc_ifu.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_ifu (
  input  logic           clk,
  input  logic           prog_valid,
  input  npc_pkg::prog_t prog,
  input  npc_pkg::xlen_t pc,
  output npc_pkg::inst_t inst
);
  import npc_pkg::*;

  inst_t      imem [IMEM_WORDS];
  xlen_t      offset;
  imem_addr_t widx;
  logic       in_range;

  // The program is written one word per clock while the core sits in reset.
  always_ff @(posedge clk) begin
    if (prog_valid) begin
      imem[prog.addr] <= prog.data;
    end
  end

  assign offset   = pc - RESET_PC;
  assign widx     = offset[IMEM_AW+1:2];
  assign in_range = offset < xlen_t'(IMEM_WORDS * 4);

  // A fetch outside the memory returns zero, which the decoder takes as illegal.
  assign inst = in_range ? imem[widx] : '0;

endmodule

`default_nettype wire

// ==== npc_idu.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_idu (
  input  npc_pkg::inst_t inst,
  output npc_pkg::ctrl_t ctrl,
  output npc_pkg::xlen_t imm
);
  import npc_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic       illegal;

  function automatic alu_op_e alu_dec(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl         = '0;
    ctrl.rs1     = inst[19:15];
    ctrl.rs2     = inst[24:20];
    ctrl.rd      = inst[11:7];
    ctrl.alu_op  = ALU_ADD;
    ctrl.wb_sel  = WB_ALU;
    ctrl.npc_sel = NPC_SNPC;
    ctrl.mem_size = MEM_WORD;
    imm          = '0;
    illegal      = 1'b0;
    case (opcode)
      OP_LUI: begin
        imm          = imm_u;
        ctrl.reg_wen = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = ALU_PASS_B;
      end
      OP_AUIPC: begin
        imm          = imm_u;
        ctrl.reg_wen = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.use_pc  = 1'b1;
        ctrl.wb_sel  = WB_DNPC;
      end
      OP_JAL: begin
        imm          = imm_j;
        ctrl.reg_wen = 1'b1;
        ctrl.wb_sel  = WB_SNPC;
        ctrl.npc_sel = NPC_DNPC;
      end
      OP_JALR: begin
        imm          = imm_i;
        ctrl.reg_wen = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.wb_sel  = WB_SNPC;
        ctrl.npc_sel = NPC_JALR;
        illegal      = funct3 != 3'b000;
      end
      OP_BRANCH: begin
        imm          = imm_b;
        ctrl.npc_sel = NPC_BRANCH;
        ctrl.br_inv  = funct3[0];
        case (funct3[2:1])
          2'b00:   ctrl.alu_op = ALU_XOR; // Equality is tested on the XOR result.
          2'b10:   ctrl.alu_op = ALU_SLT;
          2'b11:   ctrl.alu_op = ALU_SLTU;
          default: illegal = 1'b1;
        endcase
      end
      OP_LOAD: begin
        imm           = imm_i;
        ctrl.reg_wen  = 1'b1;
        ctrl.use_imm  = 1'b1;
        ctrl.mem_ren  = 1'b1;
        ctrl.wb_sel   = WB_MEM;
        ctrl.mem_sext = ~funct3[2];
        ctrl.mem_size = mem_size_e'(funct3[1:0]);
        illegal       = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OP_STORE: begin
        imm           = imm_s;
        ctrl.use_imm  = 1'b1;
        ctrl.mem_wen  = 1'b1;
        ctrl.mem_size = mem_size_e'(funct3[1:0]);
        illegal       = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OP_IMM: begin
        imm          = imm_i;
        ctrl.reg_wen = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = alu_dec(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001) begin
          illegal = funct7 != 7'b0000000;
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      OP_REG: begin
        ctrl.reg_wen = 1'b1;
        ctrl.alu_op  = alu_dec(funct3, funct7[5]);
        illegal      = (funct7 != 7'b0000000) &&
                       !((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OP_SYSTEM: begin
        ctrl.halt = 1'b1;
        illegal   = inst != INST_EBREAK; // Only ebreak is supported here.
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      ctrl.halt    = 1'b1; // An unknown encoding stops the core with no side effects.
      ctrl.reg_wen = 1'b0;
      ctrl.mem_ren = 1'b0;
      ctrl.mem_wen = 1'b0;
      ctrl.npc_sel = NPC_SNPC;
    end
  end

endmodule

`default_nettype wire

// ==== npc_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_regfile (
  input  logic              clk,
  input  logic              rst,
  input  npc_pkg::reg_idx_t rs1,
  input  npc_pkg::reg_idx_t rs2,
  input  npc_pkg::reg_idx_t rd,
  input  logic              wen,
  input  npc_pkg::xlen_t    wdata,
  output npc_pkg::xlen_t    src1,
  output npc_pkg::xlen_t    src2
);
  import npc_pkg::*;

  xlen_t regs [1:31]; // x0 has no storage.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign src1 = (rs1 == '0) ? '0 : regs[rs1];
  assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== npc_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_alu (
  input  npc_pkg::alu_op_e op,
  input  npc_pkg::xlen_t   a,
  input  npc_pkg::xlen_t   b,
  output npc_pkg::xlen_t   result
);
  import npc_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {31'b0, lt_s};
      ALU_SLTU:   result = {31'b0, lt_u};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = xlen_t'($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b; // Used by lui.
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== npc_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_lsu (
  input  logic               clk,
  input  logic               ren,
  input  logic               wen,
  input  npc_pkg::mem_size_e size,
  input  logic               sext,
  input  npc_pkg::xlen_t     addr,
  input  npc_pkg::xlen_t     wdata,
  output npc_pkg::xlen_t     rdata
);
  import npc_pkg::*;

  xlen_t      dmem [DMEM_WORDS];
  xlen_t      offset;
  dmem_addr_t widx;
  logic       in_range;
  logic [3:0] be;
  xlen_t      wdata_lanes;
  xlen_t      word;
  xlen_t      shifted;

  assign offset   = addr - DMEM_BASE;
  assign widx     = offset[DMEM_AW+1:2];
  assign in_range = offset < xlen_t'(DMEM_WORDS * 4);

  // Store data is replicated so that every enabled lane sees its bytes.
  always_comb begin
    case (size)
      MEM_BYTE: begin
        be          = 4'b0001 << addr[1:0];
        wdata_lanes = {4{wdata[7:0]}};
      end
      MEM_HALF: begin
        be          = 4'b0011 << {addr[1], 1'b0};
        wdata_lanes = {2{wdata[15:0]}};
      end
      default: begin
        be          = 4'b1111;
        wdata_lanes = wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (wen && in_range) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          dmem[widx][8*i +: 8] <= wdata_lanes[8*i +: 8];
        end
      end
    end
  end

  assign word    = in_range ? dmem[widx] : '0;
  assign shifted = word >> {addr[1:0], 3'b000};

  always_comb begin
    if (!ren) begin
      rdata = '0;
    end else begin
      case (size)
        MEM_BYTE: rdata = {{24{sext & shifted[7]}}, shifted[7:0]};
        MEM_HALF: rdata = {{16{sext & shifted[15]}}, shifted[15:0]};
        default:  rdata = shifted;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== npc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_core (
  input  logic             clk,
  input  logic             rst,
  input  logic             prog_valid,
  input  npc_pkg::prog_t   prog,
  output logic             commit_valid,
  output npc_pkg::commit_t commit,
  output logic             halt
);
  import npc_pkg::*;

  xlen_t pc;
  xlen_t snpc;
  xlen_t dnpc;
  xlen_t next_pc;
  logic  halted;
  logic  active;
  inst_t inst;
  ctrl_t ctrl;
  xlen_t imm;
  xlen_t src1;
  xlen_t src2;
  xlen_t alu_a;
  xlen_t alu_b;
  xlen_t alu_result;
  xlen_t mem_rdata;
  xlen_t wb_data;
  logic  br_cond;

  assign active = ~rst & ~halted; // One instruction retires in every active cycle.
  assign snpc   = pc + 32'd4;
  assign dnpc   = pc + imm;
  assign alu_a  = ctrl.use_pc ? pc : src1;
  assign alu_b  = ctrl.use_imm ? imm : src2;

  // XOR gives equality when the result is zero, SLT and SLTU leave their flag in bit 0.
  assign br_cond = (ctrl.alu_op == ALU_XOR) ? (alu_result == '0) : alu_result[0];

  always_comb begin
    case (ctrl.npc_sel)
      NPC_DNPC:   next_pc = dnpc;
      NPC_JALR:   next_pc = {alu_result[31:1], 1'b0};
      NPC_BRANCH: next_pc = (br_cond ^ ctrl.br_inv) ? dnpc : snpc;
      default:    next_pc = snpc;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      WB_SNPC: wb_data = snpc;
      WB_DNPC: wb_data = dnpc;
      WB_MEM:  wb_data = mem_rdata;
      default: wb_data = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else if (!halted) begin
      pc     <= next_pc;
      halted <= ctrl.halt; // The pc is frozen from the edge after ebreak.
    end
  end

  assign halt         = halted | (active & ctrl.halt);
  assign commit_valid = active;

  always_comb begin
    commit.pc      = pc;
    commit.inst    = inst;
    commit.rd_wen  = ctrl.reg_wen;
    commit.rd      = ctrl.rd;
    commit.rd_data = (ctrl.reg_wen && ctrl.rd != '0) ? wb_data : '0;
    commit.next_pc = next_pc;
  end

  npc_ifu u_ifu (
    .clk        (clk),
    .prog_valid (prog_valid & rst),
    .prog       (prog),
    .pc         (pc),
    .inst       (inst)
  );

  npc_idu u_idu (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm)
  );

  npc_regfile u_regfile (
    .clk   (clk),
    .rst   (rst),
    .rs1   (ctrl.rs1),
    .rs2   (ctrl.rs2),
    .rd    (ctrl.rd),
    .wen   (ctrl.reg_wen & active),
    .wdata (wb_data),
    .src1  (src1),
    .src2  (src2)
  );

  npc_alu u_alu (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  npc_lsu u_lsu (
    .clk   (clk),
    .ren   (ctrl.mem_ren),
    .wen   (ctrl.mem_wen & active),
    .size  (ctrl.mem_size),
    .sext  (ctrl.mem_sext),
    .addr  (alu_result),
    .wdata (src2),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== npc_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_sva (
  input logic             clk,
  input logic             rst,
  input logic             commit_valid,
  input npc_pkg::commit_t commit,
  input logic             halt
);

  int fail_count = 0;

  no_commit_in_reset: assert property (@(posedge clk) rst |-> !commit_valid)
    else begin
      $error("commit_valid is high while rst is high");
      fail_count++;
    end

  pc_aligned: assert property (@(posedge clk) disable iff (rst)
                               commit_valid |-> commit.pc[1:0] == 2'b00)
    else begin
      $error("commit.pc 0x%h is not word aligned", commit.pc);
      fail_count++;
    end

  halt_held: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else begin
      $error("halt dropped before reset");
      fail_count++;
    end

  x0_stays_zero: assert property (@(posedge clk) disable iff (rst)
                                  (commit_valid && commit.rd_wen && commit.rd == '0)
                                  |-> commit.rd_data == '0)
    else begin
      $error("a write to x0 reports nonzero data 0x%h", commit.rd_data);
      fail_count++;
    end

endmodule

bind npc_core npc_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .commit_valid (commit_valid),
  .commit       (commit),
  .halt         (halt)
);

`default_nettype wire

// ==== tb_npc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_npc;
  import npc_pkg::*;

  typedef struct packed {
    xlen_t    pc;
    logic     rd_wen;
    reg_idx_t rd;
    xlen_t    rd_data;
    xlen_t    next_pc;
  } exp_t;

  logic    clk;
  logic    rst;
  logic    prog_valid;
  prog_t   prog;
  logic    commit_valid;
  commit_t commit;
  logic    halt;

  string test_names[$];
  int    p_base[$];
  int    e_base[$];
  int    h_count[$];
  int    p_addr[$];
  xlen_t p_data[$];
  exp_t  exp_q[$];
  int    errors       = 0;
  int    failed_tests = 0;
  int    limit_cycles = 0;

  npc_core i_dut (
    .clk          (clk),
    .rst          (rst),
    .prog_valid   (prog_valid),
    .prog         (prog),
    .commit_valid (commit_valid),
    .commit       (commit),
    .halt         (halt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic read_testdata();
    int    fd;
    int    code;
    int    word_idx;
    int    wen_v;
    int    rd_v;
    int    cnt;
    xlen_t data_v;
    xlen_t pc_v;
    xlen_t npc_v;
    string tok;
    string line;
    string name;
    exp_t  e;
    fd = $fopen("npc_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open npc_testdata.txt for reading.");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        break;
      end
      case (tok)
        "#": code = $fgets(line, fd); // The rest of the line is a remark.
        "T": begin
          code = $fscanf(fd, "%s", name);
          test_names.push_back(name);
          p_base.push_back(p_addr.size());
          e_base.push_back(exp_q.size());
        end
        "P": begin
          code = $fscanf(fd, "%h %h", word_idx, data_v);
          p_addr.push_back(word_idx);
          p_data.push_back(data_v);
        end
        "E": begin
          code = $fscanf(fd, "%h %h %h %h %h", pc_v, wen_v, rd_v, data_v, npc_v);
          e.pc      = pc_v;
          e.rd_wen  = wen_v[0];
          e.rd      = reg_idx_t'(rd_v);
          e.rd_data = data_v;
          e.next_pc = npc_v;
          exp_q.push_back(e);
        end
        "H": begin
          code = $fscanf(fd, "%d", cnt);
          h_count.push_back(cnt);
        end
        default: begin
          errors++;
          $display("Unknown record '%s' in npc_testdata.txt.", tok);
        end
      endcase
    end
    $fclose(fd);
    p_base.push_back(p_addr.size()); // Closing bounds of the last test.
    e_base.push_back(exp_q.size());
    if (test_names.size() == 0 || h_count.size() != test_names.size()) begin
      errors++;
      $display("npc_testdata.txt holds no complete test.");
    end
  endtask

  // Returns the P record that loads the word at addr in test t, or -1 when there is none.
  function automatic int find_prog_word(input int t, input xlen_t addr);
    int widx;
    int found;
    widx  = int'((addr - RESET_PC) >> 2);
    found = -1;
    for (int k = p_base[t]; k < p_base[t+1]; k++) begin
      if (p_addr[k] == widx) begin
        found = k;
      end
    end
    return found;
  endfunction

  task automatic check_value(input string test, input string what, input xlen_t expected,
                             input xlen_t actual);
    assert (actual === expected) else begin
      errors++;
      $display("MISMATCH %s %s: expected 0x%h, actual 0x%h", test, what, expected, actual);
    end
  endtask

  task automatic check_commit(input int t, input int n, input exp_t e);
    string tag;
    int    idx;
    tag = $sformatf("%s #%0d", test_names[t], n);
    idx = find_prog_word(t, e.pc);
    check_value(tag, "pc", e.pc, commit.pc);
    assert (idx >= 0) else begin
      errors++;
      $display("%s: no program word is loaded at pc 0x%h.", tag, e.pc);
    end
    if (idx >= 0) begin
      check_value(tag, "inst", p_data[idx], commit.inst);
    end
    check_value(tag, "rd_wen", xlen_t'(e.rd_wen), xlen_t'(commit.rd_wen));
    if (e.rd_wen) begin
      check_value(tag, "rd", xlen_t'(e.rd), xlen_t'(commit.rd));
      check_value(tag, "rd_data", e.rd_data, commit.rd_data);
    end
    check_value(tag, "next_pc", e.next_pc, commit.next_pc);
  endtask

  // The program streams in during reset, which lasts at least four cycles.
  task automatic reset_and_load(input int t);
    int n;
    int cycles;
    n      = p_base[t+1] - p_base[t];
    cycles = (n > 4) ? n : 4;
    for (int k = 0; k < cycles; k++) begin
      @(posedge clk);
      rst        <= 1'b1;
      prog_valid <= (k < n);
      if (k < n) begin
        prog.addr <= imem_addr_t'(p_addr[p_base[t] + k]);
        prog.data <= p_data[p_base[t] + k];
      end
      @(negedge clk);
      assert (!commit_valid) else begin
        errors++;
        $display("%s: commit_valid was high during reset.", test_names[t]);
      end
      assert (k == 0 || !halt) else begin
        errors++;
        $display("%s: halt was high during reset.", test_names[t]);
      end
    end
    @(posedge clk);
    rst        <= 1'b0;
    prog_valid <= 1'b0;
  endtask

  task automatic run_test(input int t);
    int   n_exp;
    int   retired;
    int   cycles;
    int   errors_before;
    logic seen_halt;
    n_exp         = e_base[t+1] - e_base[t];
    errors_before = errors;
    retired       = 0;
    cycles        = 0;
    seen_halt     = 1'b0;
    reset_and_load(t);
    while (!seen_halt && cycles < n_exp + 20) begin
      @(negedge clk);
      cycles++;
      if (commit_valid) begin
        if (retired < n_exp) begin
          check_commit(t, retired, exp_q[e_base[t] + retired]);
        end else begin
          errors++;
          $display("%s: commit at pc 0x%h goes past the expected trace.",
                   test_names[t], commit.pc);
        end
        retired++;
      end
      seen_halt = halt;
    end
    assert (seen_halt) else begin
      errors++;
      $display("%s: halt was not raised within %0d cycles.", test_names[t], cycles);
    end
    repeat (2) begin
      @(negedge clk);
      assert (halt && !commit_valid) else begin
        errors++;
        $display("%s: the core did not stay halted after ebreak.", test_names[t]);
      end
    end
    check_value(test_names[t], "retired", xlen_t'(h_count[t]), xlen_t'(retired));
    if (errors == errors_before) begin
      $display("test %s ok, %0d retired", test_names[t], retired);
    end else begin
      failed_tests++;
      $display("test %s failed with %0d errors", test_names[t], errors - errors_before);
    end
  endtask

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, the tests did not finish.", limit_cycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int gap;
    rst        = 1'b1;
    prog_valid = 1'b0;
    prog       = '0;
    void'($urandom(32'h9a3d_291f));
    read_testdata();
    limit_cycles = exp_q.size() + p_addr.size() + 50 * test_names.size();
    if (h_count.size() == test_names.size()) begin
      for (int t = 0; t < test_names.size(); t++) begin
        run_test(t);
        gap = $urandom_range(7, 0); // Idle cycles with the core halted.
        repeat (gap) @(posedge clk);
      end
    end
    if (i_dut.u_sva.fail_count != 0) begin
      errors += i_dut.u_sva.fail_count;
      $display("Concurrent assertions failed %0d times.", i_dut.u_sva.fail_count);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", test_names.size(), failed_tests,
             errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== npc_testdata.txt ====
# Records are T name, P word_index data, E pc rd_wen rd rd_data next_pc and H retired_count.
# P and E fields are hex and the H count is decimal. Each test closes with its H line.
T alu
P 00 00500093 # addi x1, x0, 5
P 01 ffd00113 # addi x2, x0, -3
P 02 002081b3 # add x3, x1, x2
P 03 40208233 # sub x4, x1, x2
P 04 001122b3 # slt x5, x2, x1
P 05 00113333 # sltu x6, x2, x1
P 06 40115393 # srai x7, x2, 1
P 07 00409493 # slli x9, x1, 4
P 08 123455b7 # lui x11, 0x12345
P 09 00001617 # auipc x12, 0x1
P 0a 00700013 # addi x0, x0, 7
P 0b 001006b3 # add x13, x0, x1
P 0c 00100073 # ebreak
E 80000000 1 01 00000005 80000004
E 80000004 1 02 fffffffd 80000008
E 80000008 1 03 00000002 8000000c
E 8000000c 1 04 00000008 80000010
E 80000010 1 05 00000001 80000014
E 80000014 1 06 00000000 80000018
E 80000018 1 07 fffffffe 8000001c
E 8000001c 1 09 00000050 80000020
E 80000020 1 0b 12345000 80000024
E 80000024 1 0c 80001024 80000028
E 80000028 1 00 00000000 8000002c
E 8000002c 1 0d 00000005 80000030
E 80000030 0 00 00000000 80000034
H 13
T ctrl
P 00 00100093 # addi x1, x0, 1
P 01 fff00113 # addi x2, x0, -1
P 02 00208463 # beq x1, x2, +8 is not taken
P 03 00209463 # bne x1, x2, +8 is taken
P 04 00100073 # skipped
P 05 00114463 # blt x2, x1, +8 is taken
P 06 00100073 # skipped
P 07 00116463 # bltu x2, x1, +8 is not taken
P 08 00117463 # bgeu x2, x1, +8 is taken
P 09 00100073 # skipped
P 0a 00115463 # bge x2, x1, +8 is not taken
P 0b 00c002ef # jal x5, +12
P 0c 00100073 # skipped
P 0d 00100073 # skipped
P 0e 00d28367 # jalr x6, 13(x5)
P 0f 00100073 # ebreak
E 80000000 1 01 00000001 80000004
E 80000004 1 02 ffffffff 80000008
E 80000008 0 00 00000000 8000000c
E 8000000c 0 00 00000000 80000014
E 80000014 0 00 00000000 8000001c
E 8000001c 0 00 00000000 80000020
E 80000020 0 00 00000000 80000028
E 80000028 0 00 00000000 8000002c
E 8000002c 1 05 80000030 80000038
E 80000038 1 06 8000003c 8000003c
E 8000003c 0 00 00000000 80000040
H 11
T mem
P 00 800010b7 # lui x1, 0x80001
P 01 f8000113 # addi x2, x0, -128
P 02 12300193 # addi x3, x0, 0x123
P 03 0020a023 # sw x2, 0(x1)
P 04 003080a3 # sb x3, 1(x1)
P 05 00309323 # sh x3, 6(x1)
P 06 00008203 # lb x4, 0(x1)
P 07 0010c283 # lbu x5, 1(x1)
P 08 00209303 # lh x6, 2(x1)
P 09 0000d383 # lhu x7, 0(x1)
P 0a 00609403 # lh x8, 6(x1)
P 0b 0000a483 # lw x9, 0(x1)
P 0c 00100073 # ebreak
E 80000000 1 01 80001000 80000004
E 80000004 1 02 ffffff80 80000008
E 80000008 1 03 00000123 8000000c
E 8000000c 0 00 00000000 80000010
E 80000010 0 00 00000000 80000014
E 80000014 0 00 00000000 80000018
E 80000018 1 04 ffffff80 8000001c
E 8000001c 1 05 00000023 80000020
E 80000020 1 06 ffffffff 80000024
E 80000024 1 07 00002380 80000028
E 80000028 1 08 00000123 8000002c
E 8000002c 1 09 ffff2380 80000030
E 80000030 0 00 00000000 80000034
H 13

// ==== build.f ====
npc_pkg.sv
npc_ifu.sv
npc_idu.sv
npc_regfile.sv
npc_alu.sv
npc_lsu.sv
npc_core.sv
npc_sva.sv
tb_npc.sv

// ==== Bender.yml ====
package:
  name: npc

sources:
  - npc_pkg.sv
  - npc_ifu.sv
  - npc_idu.sv
  - npc_regfile.sv
  - npc_alu.sv
  - npc_lsu.sv
  - npc_core.sv
  - target: simulation
    files:
      - npc_sva.sv
      - tb_npc.sv
